// File: flist.f
+incdir+verif
src/bp_pkg.sv
src/gbpt_wr_if.sv
src/gbpt_array.sv
src/gbpt_updater.sv
src/gbpt_ctrl.sv
src/gbpt_top.sv
verif/gbpt_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module gbpt_tb -f flist.f -o gbpt_sim \
    && ./obj_dir/gbpt_sim \
    || { echo "run failed"; exit 1; }

// File: src/bp_pkg.sv
// ----------------------------------------------------------
// widths, typedefs and helper functions shared by the global
// branch prediction table; design modules pull them in with
// a wildcard import in the module header
// ----------------------------------------------------------

package bp_pkg;

    // fetch geometry
    localparam int FETCH_LANES     = 8;
    localparam int LOG_FETCH_LANES = 3;

    // table geometry
    localparam int GBPT_SETS     = 256;
    localparam int LOG_GBPT_SETS = 8;

    typedef logic [37:0]                   PC38_t;
    typedef logic [37-LOG_FETCH_LANES:0]   fetch_idx_t;
    typedef logic [LOG_FETCH_LANES-1:0]    fetch_lane_t;
    typedef logic [7:0]                    GH_t;
    typedef logic [7:0]                    ASID_t;
    typedef logic [LOG_GBPT_SETS-1:0]      GBPT_idx_t;

    // two-bit counter as {taken, strong}
    typedef logic [1:0] tbc_t;

    localparam tbc_t TBC_WN = 2'b00;
    localparam tbc_t TBC_SN = 2'b01;
    localparam tbc_t TBC_WT = 2'b10;
    localparam tbc_t TBC_ST = 2'b11;

    // one counter per lane, lane n in bits 2n+1:2n
    typedef logic [2*FETCH_LANES-1:0] GBPT_set_t;

    localparam int GBPT_BYTES = $bits(GBPT_set_t) / 8;

    typedef enum logic {CLEARING, RUNNING} ctrl_state_t;

    // lane bits of an instruction address
    function automatic fetch_lane_t pc_lane(PC38_t pc38);
        return pc38[LOG_FETCH_LANES-1:0];
    endfunction

    // fetch index folded by truncation, then history and asid mixed in
    function automatic GBPT_idx_t index_hash(PC38_t pc38, GH_t gh, ASID_t asid);
        GBPT_idx_t folded;
        folded = pc38[LOG_FETCH_LANES +: LOG_GBPT_SETS];
        return folded ^ gh ^ asid;
    endfunction

    // counter transition; weak-not-taken is the reset state for fast warmup
    function automatic tbc_t tbc_next(tbc_t cur, logic taken);
        tbc_t nxt;
        if (taken) begin
            nxt = (cur == TBC_SN) ? TBC_WN : TBC_ST;
        end else begin
            nxt = (cur == TBC_ST) ? TBC_WT : TBC_SN;
        end
        return nxt;
    endfunction

endpackage

// File: src/gbpt_array.sv
// ----------------------------------------------------------
// table storage with two registered read ports and one
// byte-enabled write port; reads of a set written in the same
// cycle return the old contents
// ----------------------------------------------------------

`timescale 1ns/1ns

module gbpt_array #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 16
) (
    input  logic                     CLK,
    input  logic                     nRST,

    // lookup port
    input  logic                     rd0_en,
    input  logic [$clog2(DEPTH)-1:0] rd0_index,
    output logic [WIDTH-1:0]         rd0_set,

    // update read port
    input  logic                     rd1_en,
    input  logic [$clog2(DEPTH)-1:0] rd1_index,
    output logic [WIDTH-1:0]         rd1_set,

    gbpt_wr_if.array                 arr_wr
);

    localparam int NBYTES = WIDTH / 8;

    logic [WIDTH-1:0] mem [DEPTH];

    // ------------------------------------------------------
    // write port

    always_ff @(posedge CLK) begin
        for (int b = 0; b < NBYTES; b++) begin
            if (arr_wr.byten[b]) begin
                mem[arr_wr.index][b*8 +: 8] <= arr_wr.set[b*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------
    // read ports, data holds while the port is idle

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd0_set <= '0;
            rd1_set <= '0;
        end else begin
            if (rd0_en) begin
                rd0_set <= mem[rd0_index];
            end
            if (rd1_en) begin
                rd1_set <= mem[rd1_index];
            end
        end
    end

    a_wr_index_range : assert property (@(posedge CLK) disable iff (!nRST)
        (|arr_wr.byten) |-> (32'(arr_wr.index) < DEPTH))
        else $error("write index %0d beyond table depth", arr_wr.index);

endmodule

// File: src/gbpt_ctrl.sv
// ----------------------------------------------------------
// control for the prediction table: clear sweep after reset,
// gating of lookups and updates, write port arbitration and
// the lookup path with its per-lane decode
// ----------------------------------------------------------

`timescale 1ns/1ns

module gbpt_ctrl import bp_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,

    input  ASID_t                  arch_asid,

    // lookup request and response
    input  logic                   read_req_valid,
    input  fetch_idx_t             read_req_fetch_index,
    input  GH_t                    read_req_gh,
    output logic [FETCH_LANES-1:0] read_resp_taken_by_lane,

    // update strobe, gated towards the updater
    input  logic                   update_valid,
    output logic                   upd_en,

    output logic                   busy,

    // array read port 0
    output logic                   rd0_en,
    output GBPT_idx_t              rd0_index,
    input  GBPT_set_t              rd0_set,

    gbpt_wr_if.array               upd_wr,
    gbpt_wr_if.writer              arr_wr
);

    ctrl_state_t state;
    GBPT_idx_t   sweep_idx;
    logic        rd_issued;

    // ------------------------------------------------------
    // clear sweep, one set per cycle from 0 up

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= CLEARING;
            sweep_idx <= '0;
        end else begin
            case (state)
                CLEARING: begin
                    sweep_idx <= sweep_idx + GBPT_idx_t'(1);
                    if (sweep_idx == GBPT_idx_t'(GBPT_SETS - 1)) begin
                        state <= RUNNING;
                    end
                end
                default: begin
                    state <= RUNNING;
                end
            endcase
        end
    end

    assign busy   = (state == CLEARING);
    assign upd_en = update_valid && (state == RUNNING);

    // sweep owns the write port while clearing
    always_comb begin
        if (state == CLEARING) begin
            arr_wr.byten = '1;
            arr_wr.index = sweep_idx;
            arr_wr.set   = {FETCH_LANES{TBC_WN}};
        end else begin
            arr_wr.byten = upd_wr.byten;
            arr_wr.index = upd_wr.index;
            arr_wr.set   = upd_wr.set;
        end
    end

    // ------------------------------------------------------
    // lookup path

    assign rd0_en    = read_req_valid && (state == RUNNING);
    assign rd0_index = index_hash({read_req_fetch_index, {LOG_FETCH_LANES{1'b0}}},
                                  read_req_gh, arch_asid);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_issued <= 1'b0;
        end else begin
            rd_issued <= rd0_en;
        end
    end

    // taken bit is the msb of each counter
    always_comb begin
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            read_resp_taken_by_lane[lane] = rd_issued && rd0_set[2*lane+1];
        end
    end

    a_no_upd_while_clearing : assert property (@(posedge CLK) disable iff (!nRST)
        (state == CLEARING) |-> !(|upd_wr.byten))
        else $error("updater write during clear sweep");

endmodule

// File: src/gbpt_top.sv
// ----------------------------------------------------------
// top level of the global branch prediction table; lookups
// and updates come in as plain strobes, the per-lane taken
// bits and the clear busy level go out as plain levels
// ----------------------------------------------------------

`timescale 1ns/1ns

module gbpt_top import bp_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,

    input  ASID_t                  arch_asid,

    // lookup
    input  logic                   read_req_valid,
    input  fetch_idx_t             read_req_fetch_index,
    input  GH_t                    read_req_gh,
    output logic [FETCH_LANES-1:0] read_resp_taken_by_lane,

    // update
    input  logic                   update_valid,
    input  PC38_t                  update_pc38,
    input  GH_t                    update_gh,
    input  logic                   update_taken,

    output logic                   busy
);

    logic      upd_en;
    logic      rd0_en;
    GBPT_idx_t rd0_index;
    GBPT_set_t rd0_set;
    logic      rd1_en;
    GBPT_idx_t rd1_index;
    GBPT_set_t rd1_set;

    gbpt_wr_if upd_wr ();
    gbpt_wr_if arr_wr ();

    gbpt_ctrl u_ctrl (
        .CLK                     (CLK),
        .nRST                    (nRST),
        .arch_asid               (arch_asid),
        .read_req_valid          (read_req_valid),
        .read_req_fetch_index    (read_req_fetch_index),
        .read_req_gh             (read_req_gh),
        .read_resp_taken_by_lane (read_resp_taken_by_lane),
        .update_valid            (update_valid),
        .upd_en                  (upd_en),
        .busy                    (busy),
        .rd0_en                  (rd0_en),
        .rd0_index               (rd0_index),
        .rd0_set                 (rd0_set),
        .upd_wr                  (upd_wr.array),
        .arr_wr                  (arr_wr.writer)
    );

    gbpt_updater u_updater (
        .CLK          (CLK),
        .nRST         (nRST),
        .arch_asid    (arch_asid),
        .upd_en       (upd_en),
        .update_pc38  (update_pc38),
        .update_gh    (update_gh),
        .update_taken (update_taken),
        .rd1_en       (rd1_en),
        .rd1_index    (rd1_index),
        .rd1_set      (rd1_set),
        .upd_wr       (upd_wr.writer)
    );

    gbpt_array #(
        .DEPTH (GBPT_SETS),
        .WIDTH ($bits(GBPT_set_t))
    ) u_array (
        .CLK       (CLK),
        .nRST      (nRST),
        .rd0_en    (rd0_en),
        .rd0_index (rd0_index),
        .rd0_set   (rd0_set),
        .rd1_en    (rd1_en),
        .rd1_index (rd1_index),
        .rd1_set   (rd1_set),
        .arr_wr    (arr_wr.array)
    );

endmodule

// File: src/gbpt_updater.sv
// ----------------------------------------------------------
// two-stage read-modify-write of one counter per update;
// read at the accepting edge, write one edge later, with the
// just-written set forwarded to a back-to-back update
// ----------------------------------------------------------

`timescale 1ns/1ns

module gbpt_updater import bp_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    input  ASID_t       arch_asid,

    // gated update strobe and payload
    input  logic        upd_en,
    input  PC38_t       update_pc38,
    input  GH_t         update_gh,
    input  logic        update_taken,

    // array read port 1
    output logic        rd1_en,
    output GBPT_idx_t   rd1_index,
    input  GBPT_set_t   rd1_set,

    gbpt_wr_if.writer   upd_wr
);

    // write stage
    logic        wr_valid;
    fetch_lane_t wr_lane;
    logic        wr_taken;
    GBPT_idx_t   wr_index;

    // forwarding
    logic        wr_fwd;
    GBPT_set_t   fwd_set;

    GBPT_set_t   base_set;
    GBPT_set_t   new_set;

    // ------------------------------------------------------
    // read stage

    always_comb begin
        rd1_en    = upd_en;
        rd1_index = index_hash(update_pc38, update_gh, arch_asid);
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_valid <= 1'b0;
            wr_fwd   <= 1'b0;
        end else begin
            wr_valid <= upd_en;
            // array read misses the write landing on this same edge
            wr_fwd   <= upd_en && wr_valid && (rd1_index == wr_index);
        end
    end

    always_ff @(posedge CLK) begin
        if (upd_en) begin
            wr_lane  <= pc_lane(update_pc38);
            wr_taken <= update_taken;
            wr_index <= rd1_index;
        end
        // set going into the array this cycle
        fwd_set <= new_set;
    end

    // ------------------------------------------------------
    // write stage

    always_comb begin
        base_set = wr_fwd ? fwd_set : rd1_set;
        new_set  = base_set;
        // only the updated lane's counter moves
        new_set[2*wr_lane +: 2] = tbc_next(base_set[2*wr_lane +: 2], wr_taken);
    end

    always_comb begin
        upd_wr.byten = {GBPT_BYTES{wr_valid}};
        upd_wr.index = wr_index;
        upd_wr.set   = new_set;
    end

    a_byten_whole : assert property (@(posedge CLK) disable iff (!nRST)
        (&upd_wr.byten) || !(|upd_wr.byten))
        else $error("partial byte enable on update write");

endmodule

// File: src/gbpt_wr_if.sv
// ----------------------------------------------------------
// write request into the table array; the updater drives one
// into the control block, which drives the other into the array
// ----------------------------------------------------------

`timescale 1ns/1ns

interface gbpt_wr_if import bp_pkg::*; ();

    // nonzero byte enables mean a write this cycle
    logic [GBPT_BYTES-1:0] byten;
    GBPT_idx_t             index;
    GBPT_set_t             set;

    modport writer (
        output byten, index, set
    );

    modport array (
        input byten, index, set
    );

endinterface

// File: verif/gbpt_model.svh
// ----------------------------------------------------------
// reference model for the prediction table testbench; a shadow
// table stepped once per rising edge, included in the tb module
// ----------------------------------------------------------

`ifndef GBPT_MODEL_SVH
`define GBPT_MODEL_SVH

logic [15:0] shadow [256];
int          clear_cnt;
logic        pend_valid;
logic [7:0]  pend_idx;
logic [15:0] pend_set;
logic [7:0]  exp_resp;
logic        exp_busy;

// address bits above the lane, xor history, xor asid
function automatic logic [7:0] fold_index(logic [7:0] addr, logic [7:0] gh, logic [7:0] asid);
    return addr ^ gh ^ asid;
endfunction

// counter as {taken, strong}
function automatic logic [1:0] next_counter(logic [1:0] c, logic taken);
    case ({taken, c})
        3'b0_00: return 2'b01;
        3'b0_01: return 2'b01;
        3'b0_10: return 2'b01;
        3'b0_11: return 2'b10;
        3'b1_01: return 2'b00;
        default: return 2'b11;
    endcase
endfunction

task automatic step_model();
    logic [7:0] h;
    logic       running;
    if (!nRST) begin
        for (int s = 0; s < 256; s++) shadow[s] = 16'h0;
        clear_cnt  = 0;
        pend_valid = 1'b0;
        exp_resp   = 8'h0;
        exp_busy   = 1'b1;
    end else begin
        running  = (clear_cnt >= 256);
        // lookup sees the table before this edge's write
        exp_resp = 8'h0;
        if (running && read_req_valid) begin
            h = fold_index(read_req_fetch_index[7:0], read_req_gh, arch_asid);
            for (int n = 0; n < 8; n++) exp_resp[n] = shadow[h][2*n+1];
        end
        if (pend_valid) shadow[pend_idx] = pend_set;
        pend_valid = running && update_valid;
        if (pend_valid) begin
            pend_idx = fold_index(update_pc38[10:3], update_gh, arch_asid);
            pend_set = shadow[pend_idx];
            pend_set[2*update_pc38[2:0] +: 2] =
                next_counter(shadow[pend_idx][2*update_pc38[2:0] +: 2], update_taken);
        end
        if (clear_cnt < 256) clear_cnt++;
        exp_busy = (clear_cnt < 256);
    end
endtask

`endif

// File: verif/gbpt_tb.sv
// ----------------------------------------------------------
// testbench for the prediction table top level: clear sweep,
// a directed stimulus table and a random phase against a model
// ----------------------------------------------------------

`timescale 1ns/1ns

module gbpt_tb import bp_pkg::*; ();

    logic                   CLK;
    logic                   nRST;
    ASID_t                  arch_asid;
    logic                   read_req_valid;
    fetch_idx_t             read_req_fetch_index;
    GH_t                    read_req_gh;
    logic [FETCH_LANES-1:0] read_resp_taken_by_lane;
    logic                   update_valid;
    PC38_t                  update_pc38;
    GH_t                    update_gh;
    logic                   update_taken;
    logic                   busy;

    typedef struct {
        logic                   lv;
        fetch_idx_t             fi;
        GH_t                    lgh;
        logic                   uv;
        PC38_t                  pc;
        GH_t                    ugh;
        logic                   tk;
        ASID_t                  asid;
        logic                   chk;
        logic [FETCH_LANES-1:0] exp;
    } row_t;

    row_t       rows[$];
    logic       monitor_on = 1'b0;
    integer     seed = 32'ha59eeb0c;
    // small index pool so that random traffic collides often
    logic [7:0] pool [4] = '{8'h12, 8'h13, 8'h40, 8'h41};

    `include "gbpt_model.svh"

    gbpt_top UUT (.*);

    always #50 CLK = ~CLK;

    always @(posedge CLK) step_model();

    task automatic fail_now(string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_lanes(logic [FETCH_LANES-1:0] got, logic [FETCH_LANES-1:0] exp,
                               string what);
        if (got !== exp) fail_now($sformatf("%s lanes got %b expected %b", what, got, exp));
    endtask

    task automatic check_busy(logic got, logic exp);
        if (got !== exp) fail_now($sformatf("busy got %b expected %b", got, exp));
    endtask

    // every response and the busy level against the model
    always @(negedge CLK) begin
        if (monitor_on) begin
            check_busy(busy, exp_busy);
            check_lanes(read_resp_taken_by_lane, exp_resp, "model");
        end
    end

    function automatic PC38_t make_pc(logic [7:0] idx, fetch_lane_t lane);
        return {27'd0, idx, lane};
    endfunction

    task automatic add_row(logic lv, logic [7:0] fi, GH_t lgh, logic uv, PC38_t pc,
                           logic tk, ASID_t asid, logic chk, logic [7:0] exp);
        row_t r;
        r = '{lv, {27'd0, fi}, lgh, uv, pc, 8'h0, tk, asid, chk, exp};
        rows.push_back(r);
    endtask

    task automatic drive(logic lv, fetch_idx_t fi, GH_t lgh, logic uv, PC38_t pc, GH_t ugh,
                         logic tk, ASID_t asid);
        read_req_valid       <= lv;
        read_req_fetch_index <= fi;
        read_req_gh          <= lgh;
        update_valid         <= uv;
        update_pc38          <= pc;
        update_gh            <= ugh;
        update_taken         <= tk;
        arch_asid            <= asid;
    endtask

    initial begin
        int         busy_cycles;
        logic       done;
        logic [7:0] pi;
        CLK                  = 1'b0;
        nRST                 = 1'b0;
        arch_asid            = '0;
        read_req_valid       = 1'b0;
        read_req_fetch_index = '0;
        read_req_gh          = '0;
        update_valid         = 1'b0;
        update_pc38          = '0;
        update_gh            = '0;
        update_taken         = 1'b0;

        // ---------------------------------------------------------
        // directed table: lv fi lgh uv pc tk asid chk exp
        add_row(1, 8'h40, 0, 0, '0, 0, 0, 1, 8'h00);
        add_row(1, 8'h12, 0, 1, make_pc(8'h12, 3), 1, 0, 1, 8'h00);
        add_row(0, 8'h00, 0, 1, make_pc(8'h12, 3), 1, 0, 0, 8'h00);
        add_row(0, 8'h00, 0, 0, '0, 0, 0, 0, 8'h00);
        add_row(1, 8'h12, 0, 0, '0, 0, 0, 1, 8'h08);
        add_row(0, 8'h00, 0, 1, make_pc(8'h12, 5), 1, 0, 0, 8'h00);
        add_row(0, 8'h00, 0, 1, make_pc(8'h12, 6), 1, 0, 0, 8'h00);
        add_row(0, 8'h00, 0, 0, '0, 0, 0, 0, 8'h00);
        add_row(1, 8'h12, 0, 0, '0, 0, 0, 1, 8'h68);
        add_row(0, 8'h00, 0, 1, make_pc(8'h12, 5), 0, 0, 0, 8'h00);
        add_row(0, 8'h00, 0, 0, '0, 0, 0, 0, 8'h00);
        add_row(1, 8'h12, 0, 0, '0, 0, 0, 1, 8'h68);
        add_row(0, 8'h00, 0, 1, make_pc(8'h12, 5), 0, 0, 0, 8'h00);
        add_row(0, 8'h00, 0, 0, '0, 0, 0, 0, 8'h00);
        add_row(1, 8'h12, 0, 0, '0, 0, 0, 1, 8'h48);
        add_row(0, 8'h00, 0, 1, make_pc(8'h12, 5), 1, 0, 0, 8'h00);
        add_row(0, 8'h00, 0, 0, '0, 0, 0, 0, 8'h00);
        add_row(1, 8'h12, 0, 0, '0, 0, 0, 1, 8'h48);
        add_row(0, 8'h00, 0, 1, make_pc(8'h12, 5), 1, 0, 0, 8'h00);
        add_row(0, 8'h00, 0, 0, '0, 0, 0, 0, 8'h00);
        add_row(1, 8'h12, 0, 0, '0, 0, 0, 1, 8'h68);
        // lookup right after an update still sees the old set
        add_row(0, 8'h00, 0, 1, make_pc(8'h12, 0), 1, 0, 0, 8'h00);
        add_row(1, 8'h12, 0, 0, '0, 0, 0, 1, 8'h68);
        add_row(1, 8'h12, 0, 0, '0, 0, 0, 1, 8'h69);
        // asid and history move the set
        add_row(1, 8'h12, 0, 0, '0, 0, 8'h01, 1, 8'h00);
        add_row(1, 8'h12, 8'h10, 0, '0, 0, 0, 1, 8'h00);
        add_row(1, 8'h13, 0, 0, '0, 0, 8'h01, 1, 8'h69);
        add_row(0, 8'h00, 0, 0, '0, 0, 0, 0, 8'h00);

        // ---------------------------------------------------------
        // reset, then the clear sweep with traffic that must be dropped
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        monitor_on = 1'b1;
        busy_cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge CLK);
            if (busy) busy_cycles++;
            else done = 1'b1;
            if (!done) begin
                if (busy_cycles > 300) begin
                    $display("busy did not fall within 300 cycles after reset");
                    $display("Simulation failed");
                    $fatal(1, "timeout");
                end
                @(posedge CLK);
                // updates up to the last busy edge, none after it
                drive(1'b1, {27'd0, 8'h40}, 0, busy_cycles < 256, make_pc(8'h40, 2), 0, 1, 0);
            end
        end
        if (busy_cycles != 256)
            fail_now($sformatf("busy high for %0d cycles instead of 256", busy_cycles));

        // directed rows, each checked one cycle after it is driven
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge CLK);
            if (i < rows.size())
                drive(rows[i].lv, rows[i].fi, rows[i].lgh, rows[i].uv, rows[i].pc,
                      rows[i].ugh, rows[i].tk, rows[i].asid);
            @(negedge CLK);
            if (i > 0 && rows[i-1].chk)
                check_lanes(read_resp_taken_by_lane, rows[i-1].exp, $sformatf("row %0d", i-1));
        end

        // random phase over a small index pool
        repeat (400) begin
            @(posedge CLK);
            pi = pool[2'($random(seed))];
            drive(1'($random(seed)), {27'd0, pi}, GH_t'($random(seed) & 1),
                  1'($random(seed)), make_pc(pool[2'($random(seed))], fetch_lane_t'($random(seed))),
                  GH_t'($random(seed) & 1), 1'($random(seed)), ASID_t'($random(seed) & 1));
        end
        @(posedge CLK);
        drive(0, '0, 0, 0, '0, 0, 0, 0);
        repeat (3) @(posedge CLK);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
